/* source/spi_defines.svh */
// SPI master sizing macros for word width, FIFO depth and SCLK divider
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// Bits per SPI word
`define SPI_DATA_WIDTH 8

// Entries in each of the TX and RX FIFOs
`define SPI_FIFO_DEPTH 16

// Occupancy count width, wide enough to hold SPI_FIFO_DEPTH itself
`define SPI_CNT_W 5

// clk cycles per SCLK half period
`define SPI_CLK_DIV 2

`endif

/* source/spi_pkg.sv */
// SPI master shared types for engine state, FIFO status and SPI pins
`default_nettype none
`include "spi_defines.svh"

package spi_pkg;

    // Shift engine states
    typedef enum logic [2:0] {
        idle     = 3'd0,
        load     = 3'd1,
        shift_lo = 3'd2,
        shift_hi = 3'd3,
        finish   = 3'd4
    } spi_state_e;

    // Occupancy flags of one FIFO
    typedef struct packed {
        logic                  full;
        logic                  empty;
        logic [`SPI_CNT_W-1:0] count;
    } spi_fifo_status_t;

    // Master-driven SPI lines
    typedef struct packed {
        logic sclk;
        logic cs_n;
        logic mosi;
    } spi_pins_t;

endpackage

`default_nettype wire

/* source/spi_sync_fifo.sv */
// Synchronous circular-buffer FIFO with occupancy count, full and empty flags
`timescale 1ns/1ps
`default_nettype none
`include "spi_defines.svh"

module spi_sync_fifo #(
    parameter int DEPTH = `SPI_FIFO_DEPTH,
    parameter int WIDTH = `SPI_DATA_WIDTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  logic [WIDTH-1:0]          push_data,
    input  logic                      pop,
    output logic [WIDTH-1:0]          pop_data,
    output spi_pkg::spi_fifo_status_t status
);

    // Depth is a power of two, so pointers wrap on overflow
    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [`SPI_CNT_W-1:0] count;
    logic                  full;
    logic                  empty;
    logic                  do_push;
    logic                  do_pop;

    assign full  = (count == `SPI_CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Push into a full FIFO or pop from an empty one is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + `SPI_CNT_W'(1);
                2'b01:   count <= count - `SPI_CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Head entry, read without a clock
    assign pop_data = mem[rd_ptr];

    assign status = '{full: full, empty: empty, count: count};

    // Occupancy bounded by the buffer size across any push/pop sequence
    a_count_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= `SPI_CNT_W'(DEPTH)
    );

endmodule

`default_nettype wire

/* source/spi_shift_engine.sv */
// SPI mode 0 shift engine, MSB first, driving sclk, cs_n and mosi between two FIFOs
`timescale 1ns/1ps
`default_nettype none
`include "spi_defines.svh"

module spi_shift_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  spi_pkg::spi_fifo_status_t   tx_status,
    output logic                        tx_pop,
    input  logic [`SPI_DATA_WIDTH-1:0]  tx_pop_data,
    input  spi_pkg::spi_fifo_status_t   rx_status,
    output logic                        rx_push,
    output logic [`SPI_DATA_WIDTH-1:0]  rx_push_data,
    output spi_pkg::spi_pins_t          pins,
    input  logic                        miso
);

    localparam int DIV_W = (`SPI_CLK_DIV > 1) ? $clog2(`SPI_CLK_DIV) : 1;
    localparam int BIT_W = $clog2(`SPI_DATA_WIDTH);

    spi_pkg::spi_state_e          state;
    spi_pkg::spi_state_e          state_nxt;
    logic [DIV_W-1:0]             div_cnt;
    logic [BIT_W-1:0]             bit_cnt;
    logic [`SPI_DATA_WIDTH-1:0]   tx_shift;
    logic [`SPI_DATA_WIDTH-1:0]   rx_shift;
    logic                         sclk_q;
    logic                         cs_n_q;
    logic                         div_last;
    logic                         bit_last;
    logic                         can_start;

    assign div_last  = (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));
    assign bit_last  = (bit_cnt == BIT_W'(`SPI_DATA_WIDTH - 1));
    assign can_start = !tx_status.empty && !rx_status.full;

    // Next state and FIFO strobes
    always_comb begin
        state_nxt = state;
        tx_pop    = 1'b0;
        rx_push   = 1'b0;
        case (state)
            spi_pkg::idle: begin
                if (can_start) begin
                    tx_pop    = 1'b1;
                    state_nxt = spi_pkg::load;
                end
            end
            spi_pkg::load: begin
                state_nxt = spi_pkg::shift_lo;
            end
            spi_pkg::shift_lo: begin
                if (div_last) begin
                    state_nxt = spi_pkg::shift_hi;
                end
            end
            spi_pkg::shift_hi: begin
                if (div_last) begin
                    state_nxt = bit_last ? spi_pkg::finish : spi_pkg::shift_lo;
                end
            end
            spi_pkg::finish: begin
                // Wait here while the RX FIFO has no room
                if (!rx_status.full) begin
                    rx_push = 1'b1;
                    if (!tx_status.empty) begin
                        tx_pop    = 1'b1;
                        state_nxt = spi_pkg::load;
                    end else begin
                        state_nxt = spi_pkg::idle;
                    end
                end
            end
            default: state_nxt = spi_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= spi_pkg::idle;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            tx_shift <= '0;
            sclk_q   <= 1'b0;
            cs_n_q   <= 1'b1;
        end else begin
            state <= state_nxt;
            if (tx_pop) begin
                tx_shift <= tx_pop_data;
            end
            case (state)
                spi_pkg::load: begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                end
                spi_pkg::shift_lo: begin
                    div_cnt <= div_last ? '0 : div_cnt + DIV_W'(1);
                    if (div_last) begin
                        sclk_q <= 1'b1;
                    end
                end
                spi_pkg::shift_hi: begin
                    div_cnt <= div_last ? '0 : div_cnt + DIV_W'(1);
                    if (div_last) begin
                        sclk_q <= 1'b0;
                        // Next bit onto mosi at the start of the low half
                        if (!bit_last) begin
                            bit_cnt  <= bit_cnt + BIT_W'(1);
                            tx_shift <= {tx_shift[`SPI_DATA_WIDTH-2:0], 1'b0};
                        end
                    end
                end
                default: ;
            endcase
            // Select falls on entry to load and rises whenever the engine parks
            if (state_nxt == spi_pkg::load) begin
                cs_n_q <= 1'b0;
            end else if (state_nxt == spi_pkg::idle ||
                         (state == spi_pkg::finish && rx_status.full)) begin
                cs_n_q <= 1'b1;
            end
        end
    end

    // miso captured on the rising sclk
    always_ff @(posedge clk) begin
        if (state == spi_pkg::shift_lo && div_last) begin
            rx_shift <= {rx_shift[`SPI_DATA_WIDTH-2:0], miso};
        end
    end

    assign rx_push_data = rx_shift;

    assign pins = '{sclk: sclk_q, cs_n: cs_n_q, mosi: tx_shift[`SPI_DATA_WIDTH-1]};

    // No byte is pushed into a full RX FIFO
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!rst_n)
        rx_push |-> !rx_status.full
    );

    // Mode 0 idle level while deselected
    a_sclk_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        pins.cs_n |-> !pins.sclk
    );

endmodule

`default_nettype wire

/* source/spi_master_fifo.sv */
// SPI master top level joining the TX FIFO, the shift engine and the RX FIFO
`timescale 1ns/1ps
`default_nettype none
`include "spi_defines.svh"

module spi_master_fifo (
    input  logic                        clk,
    input  logic                        rst_n,

    // Host side
    input  logic [`SPI_DATA_WIDTH-1:0]  tx_data,
    input  logic                        tx_write,
    output logic                        tx_full,
    output logic [`SPI_DATA_WIDTH-1:0]  rx_data,
    output logic                        rx_valid,
    input  logic                        rx_read,
    output logic                        rx_empty,

    // SPI side
    output logic                        sclk,
    output logic                        cs_n,
    output logic                        mosi,
    input  logic                        miso
);

    spi_pkg::spi_fifo_status_t    tx_status;
    spi_pkg::spi_fifo_status_t    rx_status;
    spi_pkg::spi_pins_t           pins;
    logic                         tx_pop;
    logic [`SPI_DATA_WIDTH-1:0]   tx_pop_data;
    logic                         rx_push;
    logic [`SPI_DATA_WIDTH-1:0]   rx_push_data;

    spi_sync_fifo #(
        .DEPTH (`SPI_FIFO_DEPTH),
        .WIDTH (`SPI_DATA_WIDTH)
    ) u_tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tx_write),
        .push_data (tx_data),
        .pop       (tx_pop),
        .pop_data  (tx_pop_data),
        .status    (tx_status)
    );

    spi_shift_engine u_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_status    (tx_status),
        .tx_pop       (tx_pop),
        .tx_pop_data  (tx_pop_data),
        .rx_status    (rx_status),
        .rx_push      (rx_push),
        .rx_push_data (rx_push_data),
        .pins         (pins),
        .miso         (miso)
    );

    spi_sync_fifo #(
        .DEPTH (`SPI_FIFO_DEPTH),
        .WIDTH (`SPI_DATA_WIDTH)
    ) u_rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_push),
        .push_data (rx_push_data),
        .pop       (rx_read),
        .pop_data  (rx_data),
        .status    (rx_status)
    );

    assign tx_full  = tx_status.full;
    assign rx_empty = rx_status.empty;
    assign rx_valid = !rx_status.empty;

    assign sclk = pins.sclk;
    assign cs_n = pins.cs_n;
    assign mosi = pins.mosi;

endmodule

`default_nettype wire

/* verif/spi_slave_model.sv */
// Behavioral mode 0 SPI slave that logs received bytes and echoes the previous one
`timescale 1ns/1ps
`default_nettype none

module spi_slave_model (
    input  wire logic rst_n,
    input  wire logic sclk,
    input  wire logic cs_n,
    input  wire logic mosi,
    output logic      miso
);

    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic [7:0] last_byte;
    int         bit_cnt;

    // Log of every byte seen on mosi, read by the testbench
    logic [7:0] rec [256];
    int         rec_count;

    // Rising sclk samples mosi, falling sclk shifts miso
    always @(posedge sclk or negedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            rx_shift  = 8'h00;
            tx_shift  = 8'h00;
            last_byte = 8'h00;
            bit_cnt   = 0;
            rec_count = 0;
        end else if (!cs_n) begin
            if (sclk) begin
                // Rising edge samples mosi
                rx_shift = {rx_shift[6:0], mosi};
                bit_cnt  = bit_cnt + 1;
                if (bit_cnt == 8) begin
                    rec[rec_count[7:0]] = rx_shift;
                    rec_count = rec_count + 1;
                    last_byte = rx_shift;
                end
            end else begin
                // Falling edge presents the next miso bit
                if (bit_cnt == 8) begin
                    bit_cnt  = 0;
                    tx_shift = last_byte;
                end else begin
                    tx_shift = {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

    // MSB of the answer is already in place when cs_n falls
    assign miso = tx_shift[7];

endmodule

`default_nettype wire

/* verif/tb_spi_master_fifo.sv */
// Table-driven testbench for the FIFO-buffered SPI master with a loopback slave
`timescale 1ns/1ps
`default_nettype none
`include "spi_defines.svh"

module tb_spi_master_fifo;

    localparam int NUM_TESTS  = 4;
    localparam int WAIT_LIMIT = 2000;
    // Slightly longer than one byte transfer
    localparam int WRITE_GAP  = 2 * `SPI_CLK_DIV * 8 + 8;

    typedef struct packed {
        logic [7:0]  nbytes;
        logic        use_lfsr;
        logic        hold_reads;
        logic        interleave;
        logic [31:0] fixed;
    } test_entry_t;

    logic       clk;
    logic       rst_n;
    logic [7:0] tx_data;
    logic       tx_write;
    logic       tx_full;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_read;
    logic       rx_empty;
    logic       sclk;
    logic       cs_n;
    logic       mosi;
    logic       miso;

    test_entry_t tests [NUM_TESTS];
    logic [7:0]  exp_rx [$];
    logic [7:0]  exp_slave [$];
    logic [7:0]  prev_tx;
    logic [15:0] lfsr;
    int          errors;
    int          test_errors;
    int          checks;
    int          cs_rises;
    int          slave_checked;

    spi_master_fifo u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .tx_write (tx_write),
        .tx_full  (tx_full),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_read  (rx_read),
        .rx_empty (rx_empty),
        .sclk     (sclk),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .miso     (miso)
    );

    spi_slave_model u_slave (
        .rst_n (rst_n),
        .sclk  (sclk),
        .cs_n  (cs_n),
        .mosi  (mosi),
        .miso  (miso)
    );

    always #10 clk = ~clk;

    always @(posedge cs_n) begin
        cs_rises = cs_rises + 1;
    end

    // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic lfsr_byte(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors      = errors + 1;
            test_errors = test_errors + 1;
        end
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        errors      = errors + 1;
        test_errors = test_errors + 1;
    endtask

    // Drives one write and leaves tx_write high; the FIFO's view of full is sampled
    task automatic write_byte(input logic [7:0] b, output logic accepted);
        @(posedge clk);
        tx_write <= 1'b1;
        tx_data  <= b;
        @(negedge clk);
        accepted = !tx_full;
        if (accepted) begin
            exp_rx.push_back(prev_tx);
            exp_slave.push_back(b);
            prev_tx = b;
        end
    endtask

    task automatic idle_host();
        @(posedge clk);
        tx_write <= 1'b0;
        rx_read  <= 1'b0;
    endtask

    task automatic read_byte();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!rx_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rx_valid) begin
            report_error("Timed out waiting for rx_valid");
        end else if (exp_rx.size() == 0) begin
            report_error("Received a byte that no write accounts for");
        end else begin
            check("rx_data", {24'h0, rx_data}, {24'h0, exp_rx.pop_front()});
            @(posedge clk);
            rx_read <= 1'b1;
            @(posedge clk);
            rx_read <= 1'b0;
        end
    endtask

    task automatic wait_slave_count(input int n);
        int waited;
        waited = 0;
        while (u_slave.rec_count < n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (u_slave.rec_count < n) begin
            report_error("Timed out waiting for the slave to receive all bytes");
        end
    endtask

    task automatic next_byte(input test_entry_t t, input int k, output logic [7:0] b);
        if (t.use_lfsr) begin
            lfsr_byte(b);
        end else begin
            b = t.fixed[31 - 8 * k -: 8];
        end
    endtask

    task automatic run_backpressure(input test_entry_t t);
        logic [7:0] b;
        logic       accepted;
        int         n;
        n        = 0;
        accepted = 1'b1;
        while (accepted && n < int'(t.nbytes)) begin
            next_byte(t, n, b);
            write_byte(b, accepted);
            idle_host();
            if (accepted) begin
                n++;
                repeat (WRITE_GAP) @(posedge clk);
            end
        end
        check("write_dropped", {31'h0, accepted}, 32'h0);
        @(negedge clk);
        check("tx_full", {31'h0, tx_full}, 32'h1);
        check("cs_n", {31'h0, cs_n}, 32'h1);
        check("rx_count", {27'h0, u_dut.u_rx_fifo.status.count}, 32'd16);
        // A full RX FIFO plus a full TX FIFO
        check("accepted_writes", n, 2 * `SPI_FIFO_DEPTH);
        while (exp_rx.size() > 0 && test_errors < 4) begin
            read_byte();
        end
        // A byte taken in spite of tx_full would reach RX by now
        repeat (WRITE_GAP) @(negedge clk);
        check("rx_empty", {31'h0, rx_empty}, 32'h1);
    endtask

    task automatic run_test(input int idx);
        test_entry_t t;
        logic [7:0]  b;
        logic        accepted;
        int          start;
        int          rises;
        t     = tests[idx];
        start = u_slave.rec_count;
        if (t.hold_reads) begin
            run_backpressure(t);
        end else if (t.interleave) begin
            for (int k = 0; k < int'(t.nbytes); k++) begin
                next_byte(t, k, b);
                write_byte(b, accepted);
                idle_host();
                read_byte();
            end
        end else begin
            rises = cs_rises;
            for (int k = 0; k < int'(t.nbytes); k++) begin
                next_byte(t, k, b);
                write_byte(b, accepted);
                check("write_accepted", {31'h0, accepted}, 32'h1);
            end
            idle_host();
            wait_slave_count(start + int'(t.nbytes));
            // No deselect between bytes of a burst
            check("cs_n_rises", cs_rises - rises, 0);
            for (int k = 0; k < int'(t.nbytes); k++) begin
                read_byte();
            end
        end
        wait_slave_count(exp_slave.size());
        for (int i = slave_checked; i < exp_slave.size(); i++) begin
            check("slave_byte", {24'h0, u_slave.rec[i]}, {24'h0, exp_slave[i]});
        end
        slave_checked = exp_slave.size();
        repeat (WRITE_GAP) @(negedge clk);
        check("cs_n_idle", {31'h0, cs_n}, 32'h1);
    endtask

    // Watchdog sized from the total byte count of the table
    initial begin
        longint total;
        longint limit;
        #1;
        total = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total += longint'(tests[i].nbytes);
        end
        limit = total * 16 * `SPI_CLK_DIV * 20 * 4 + 20000;
        #(limit);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        tests[0] = '{nbytes: 8'd1,  use_lfsr: 1'b0, hold_reads: 1'b0, interleave: 1'b0,
                     fixed: 32'h3C00_0000};
        tests[1] = '{nbytes: 8'd12, use_lfsr: 1'b1, hold_reads: 1'b0, interleave: 1'b0,
                     fixed: 32'h0};
        tests[2] = '{nbytes: 8'd40, use_lfsr: 1'b1, hold_reads: 1'b1, interleave: 1'b0,
                     fixed: 32'h0};
        tests[3] = '{nbytes: 8'd4,  use_lfsr: 1'b0, hold_reads: 1'b0, interleave: 1'b1,
                     fixed: 32'h00FF_817E};
        clk           = 1'b0;
        rst_n         = 1'b0;
        tx_data       = 8'h00;
        tx_write      = 1'b0;
        rx_read       = 1'b0;
        prev_tx       = 8'h00;
        lfsr          = 16'h0002;
        errors        = 0;
        checks        = 0;
        slave_checked = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Post-reset levels
        test_errors = 0;
        @(negedge clk);
        check("cs_n", {31'h0, cs_n}, 32'h1);
        check("sclk", {31'h0, sclk}, 32'h0);
        check("rx_empty", {31'h0, rx_empty}, 32'h1);
        check("rx_valid", {31'h0, rx_valid}, 32'h0);
        check("tx_full", {31'h0, tx_full}, 32'h0);
        $display("test reset: %0d errors", test_errors);

        for (int i = 0; i < NUM_TESTS; i++) begin
            test_errors = 0;
            run_test(i);
            $display("test %0d: %0d errors", i, test_errors);
        end

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS + 1, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* spi_master_fifo.f */
+incdir+source
source/spi_pkg.sv
source/spi_sync_fifo.sv
source/spi_shift_engine.sv
source/spi_master_fifo.sv
verif/spi_slave_model.sv
verif/tb_spi_master_fifo.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f spi_master_fifo.f \
    --top-module tb_spi_master_fifo \
    --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_spi_master_fifo 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation binary returned status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
